// ==== include/alu_bru_defs.svh ====
`ifndef ALU_BRU_DEFS_SVH
`define ALU_BRU_DEFS_SVH

// datapath width, RV64
`define ALU_BRU_XLEN 64

// physical register file has 128 entries
`define ALU_BRU_PREG_W 7

// rob and internal rob index width
`define ALU_BRU_ROB_W 6

// fetch target queue
`define ALU_BRU_FTQ_W 4
`define ALU_BRU_FTQ_OFF_W 6

// issue queue ids seen by this unit
`define ALU_BRU_ALUIQ_ID 0
`define ALU_BRU_BRUIQ_ID 1

`endif

// ==== rtl/fu_types_pkg.sv ====
`include "alu_bru_defs.svh"

package fu_types_pkg;

    // data and pc share one width
    typedef logic [`ALU_BRU_XLEN-1:0] xdata_t;

    typedef logic [`ALU_BRU_PREG_W-1:0] preg_idx_t;

    // also used for the internal rob index
    typedef logic [`ALU_BRU_ROB_W-1:0] rob_idx_t;

    typedef logic [`ALU_BRU_FTQ_W-1:0] ftq_idx_t;

    // byte offset of the op inside its fetch block
    typedef logic [`ALU_BRU_FTQ_OFF_W-1:0] ftq_off_t;

    typedef logic [1:0] iq_id_t;

    // raw immediate as delivered by decode
    typedef logic [19:0] imm20_t;

endpackage

// ==== rtl/fu_op_pkg.sv ====
package fu_op_pkg;

    // order matters, branch class is the op_jal .. op_bgeu range
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu
    } micop_e;

    // branch kind reported to the predictor update path
    typedef enum logic [2:0] {
        br_none,
        br_cond,
        br_direct,
        br_indirect,
        br_call,
        br_ret
    } branch_type_e;

endpackage

// ==== rtl/alu_bru_ctrl.sv ====
`timescale 1ns/100ps

`include "alu_bru_defs.svh"

module alu_bru_ctrl
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   i_vld,
    input  logic   i_wb_stall,
    input  iq_id_t i_iq_id,
    input  micop_e i_micop,
    input  logic   i_rd_wen,
    output logic   o_stage_en,
    output logic   o_fu_stall,
    output logic   o_is_branch,
    output logic   o_is_auipc,
    output logic   o_willwrite_vld,
    output logic   o_fu_finished,
    output logic   o_branchwb_vld
);

    logic issue_vld;

    // a wb stall freezes both stages
    assign o_stage_en = ~i_wb_stall;
    assign o_fu_stall = i_wb_stall;

    // class decode, only the bru queue may carry jumps and branches
    assign o_is_auipc = (i_iq_id == iq_id_t'(`ALU_BRU_BRUIQ_ID)) && (i_micop == op_auipc);
    assign o_is_branch = (i_iq_id == iq_id_t'(`ALU_BRU_BRUIQ_ID)) &&
                         (i_micop >= op_jal) && (i_micop <= op_bgeu);

    assign o_willwrite_vld = issue_vld && i_rd_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_vld      <= 1'b0;
            o_fu_finished  <= 1'b0;
            o_branchwb_vld <= 1'b0;
        end else if (o_stage_en) begin
            issue_vld      <= i_vld;
            o_fu_finished  <= issue_vld;
            // branch record only for branch class ops
            o_branchwb_vld <= issue_vld && o_is_branch;
        end
    end

endmodule

// ==== rtl/operand_stage.sv ====
`timescale 1ns/100ps

`include "alu_bru_defs.svh"

module operand_stage
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  logic      clk,
    input  logic      i_stage_en,
    input  iq_id_t    i_iq_id,
    input  micop_e    i_micop,
    input  xdata_t    i_pc,
    input  xdata_t    i_pred_npc,
    input  imm20_t    i_imm20,
    input  xdata_t    i_src0,
    input  xdata_t    i_src1,
    input  logic      i_use_imm,
    input  logic      i_rd_wen,
    input  preg_idx_t i_iprd_idx,
    input  rob_idx_t  i_rob_idx,
    input  rob_idx_t  i_irob_idx,
    input  ftq_idx_t  i_ftq_idx,
    input  ftq_off_t  i_ftq_off,
    output iq_id_t    o_iq_id,
    output micop_e    o_micop,
    output xdata_t    o_pc,
    output xdata_t    o_pred_npc,
    output xdata_t    o_src0,
    output xdata_t    o_src1,
    output logic      o_use_imm,
    output logic      o_rd_wen,
    output preg_idx_t o_iprd_idx,
    output rob_idx_t  o_rob_idx,
    output rob_idx_t  o_irob_idx,
    output ftq_idx_t  o_ftq_idx,
    output ftq_off_t  o_ftq_off,
    output xdata_t    o_imm_ext,
    output xdata_t    o_fallthru,
    output xdata_t    o_auipc_val
);

    imm20_t imm20_q;

    // issue stage payload
    always_ff @(posedge clk) begin
        if (i_stage_en) begin
            o_iq_id    <= i_iq_id;
            o_micop    <= i_micop;
            o_pc       <= i_pc;
            o_pred_npc <= i_pred_npc;
            imm20_q    <= i_imm20;
            o_src0     <= i_src0;
            o_src1     <= i_src1;
            o_use_imm  <= i_use_imm;
            o_rd_wen   <= i_rd_wen;
            o_iprd_idx <= i_iprd_idx;
            o_rob_idx  <= i_rob_idx;
            o_irob_idx <= i_irob_idx;
            o_ftq_idx  <= i_ftq_idx;
            o_ftq_off  <= i_ftq_off;
        end
    end

    // shared by branch target and bypass select
    assign o_imm_ext = {{(`ALU_BRU_XLEN-20){imm20_q[19]}}, imm20_q};
    assign o_fallthru = o_pc + xdata_t'(4);
    // upper immediate sits at bit 12
    assign o_auipc_val = o_pc + {{(`ALU_BRU_XLEN-32){imm20_q[19]}}, imm20_q, 12'b0};

endmodule

// ==== rtl/alu_calc.sv ====
`timescale 1ns/100ps

`include "alu_bru_defs.svh"

module alu_calc
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  micop_e i_micop,
    input  xdata_t i_src0,
    input  xdata_t i_src1,
    output xdata_t o_result,
    output logic   o_lt,
    output logic   o_ltu,
    output logic   o_eq
);

    localparam int SHAMT_W = $clog2(`ALU_BRU_XLEN);

    logic [SHAMT_W-1:0] shamt;

    // RV64 uses the low 6 bits of src1
    assign shamt = i_src1[SHAMT_W-1:0];

    // comparators also feed branch resolution
    assign o_lt  = $signed(i_src0) < $signed(i_src1);
    assign o_ltu = i_src0 < i_src1;
    assign o_eq  = i_src0 == i_src1;

    always_comb begin
        case (i_micop)
            op_add:  o_result = i_src0 + i_src1;
            op_sub:  o_result = i_src0 - i_src1;
            op_sll:  o_result = i_src0 << shamt;
            op_slt:  o_result = xdata_t'(o_lt);
            op_sltu: o_result = xdata_t'(o_ltu);
            op_xor:  o_result = i_src0 ^ i_src1;
            op_srl:  o_result = i_src0 >> shamt;
            op_sra:  o_result = xdata_t'($signed(i_src0) >>> shamt);
            op_or:   o_result = i_src0 | i_src1;
            op_and:  o_result = i_src0 & i_src1;
            // decode already placed the shifted immediate in src1
            op_lui:  o_result = i_src1;
            default: o_result = '0;
        endcase
    end

endmodule

// ==== rtl/branch_resolve.sv ====
`timescale 1ns/100ps

module branch_resolve
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  micop_e       i_micop,
    input  logic         i_is_branch,
    input  xdata_t       i_pc,
    input  xdata_t       i_pred_npc,
    input  xdata_t       i_src0,
    input  xdata_t       i_imm_ext,
    input  xdata_t       i_fallthru,
    input  preg_idx_t    i_iprd_idx,
    input  logic         i_lt,
    input  logic         i_ltu,
    input  logic         i_eq,
    output logic         o_taken,
    output xdata_t       o_target,
    output xdata_t       o_npc,
    output logic         o_mispred,
    output branch_type_e o_type
);

    logic   is_jalr;
    logic   is_cond;
    xdata_t pc_rel_target;
    xdata_t jalr_target;

    assign is_jalr = (i_micop == op_jalr);
    assign is_cond = (i_micop >= op_beq) && (i_micop <= op_bgeu);

    // jal and conditional branches are pc relative
    assign pc_rel_target = i_pc + i_imm_ext;
    assign jalr_target   = i_src0 + i_imm_ext;

    always_comb begin
        case (i_micop)
            op_jal:  o_taken = 1'b1;
            op_jalr: o_taken = 1'b1;
            op_beq:  o_taken = i_eq;
            op_bne:  o_taken = ~i_eq;
            op_blt:  o_taken = i_lt;
            op_bge:  o_taken = ~i_lt;
            op_bltu: o_taken = i_ltu;
            op_bgeu: o_taken = ~i_ltu;
            default: o_taken = 1'b0;
        endcase
    end

    assign o_target = is_jalr ? jalr_target : pc_rel_target;
    assign o_npc    = o_taken ? o_target : i_fallthru;

    // compared against the frontend prediction
    assign o_mispred = i_is_branch && (o_npc != i_pred_npc);

    // call and ret guessed from the destination register
    always_comb begin
        if (is_jalr && (i_iprd_idx == preg_idx_t'(1))) begin
            o_type = br_call;
        end else if (is_jalr && (i_iprd_idx == preg_idx_t'(0))) begin
            o_type = br_ret;
        end else if (is_jalr) begin
            o_type = br_indirect;
        end else if (i_micop == op_jal) begin
            o_type = br_direct;
        end else if (is_cond) begin
            o_type = br_cond;
        end else begin
            o_type = br_none;
        end
    end

endmodule

// ==== rtl/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  logic         clk,
    input  logic         i_stage_en,
    input  logic         i_is_branch,
    input  logic         i_is_auipc,
    input  xdata_t       i_alu_result,
    input  xdata_t       i_fallthru,
    input  xdata_t       i_auipc_val,
    input  rob_idx_t     i_rob_idx,
    input  rob_idx_t     i_irob_idx,
    input  logic         i_use_imm,
    input  logic         i_rd_wen,
    input  preg_idx_t    i_iprd_idx,
    input  ftq_idx_t     i_ftq_idx,
    input  ftq_off_t     i_ftq_off,
    input  logic         i_taken,
    input  xdata_t       i_target,
    input  xdata_t       i_npc,
    input  logic         i_mispred,
    input  branch_type_e i_type,
    output preg_idx_t    o_willwrite_rd_idx,
    output xdata_t       o_willwrite_data,
    output rob_idx_t     o_wb_rob_idx,
    output rob_idx_t     o_wb_irob_idx,
    output logic         o_wb_use_imm,
    output logic         o_wb_rd_wen,
    output preg_idx_t    o_wb_iprd_idx,
    output xdata_t       o_wb_result,
    output branch_type_e o_br_type,
    output rob_idx_t     o_br_rob_idx,
    output ftq_idx_t     o_br_ftq_idx,
    output logic         o_br_mispred,
    output logic         o_br_taken,
    output ftq_off_t     o_br_fallthru_off,
    output xdata_t       o_br_target,
    output xdata_t       o_br_npc
);

    // jumps write the link address, auipc its sum
    assign o_willwrite_data = i_is_branch ? i_fallthru :
                              i_is_auipc  ? i_auipc_val :
                              i_alu_result;
    assign o_willwrite_rd_idx = i_iprd_idx;

    always_ff @(posedge clk) begin
        if (i_stage_en) begin
            // common result record
            o_wb_rob_idx  <= i_rob_idx;
            o_wb_irob_idx <= i_irob_idx;
            o_wb_use_imm  <= i_use_imm;
            o_wb_rd_wen   <= i_rd_wen;
            o_wb_iprd_idx <= i_iprd_idx;
            o_wb_result   <= o_willwrite_data;
            // branch record
            o_br_type         <= i_type;
            o_br_rob_idx      <= i_rob_idx;
            o_br_ftq_idx      <= i_ftq_idx;
            o_br_mispred      <= i_mispred;
            o_br_taken        <= i_taken;
            o_br_fallthru_off <= i_ftq_off + ftq_off_t'(4);
            o_br_target       <= i_target;
            o_br_npc          <= i_npc;
        end
    end

endmodule

// ==== rtl/alu_bru.sv ====
`timescale 1ns/100ps

module alu_bru
    import fu_types_pkg::*;
    import fu_op_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_vld,
    input  iq_id_t       i_iq_id,
    input  micop_e       i_micop,
    input  xdata_t       i_pc,
    input  xdata_t       i_pred_npc,
    input  imm20_t       i_imm20,
    input  xdata_t       i_src0,
    input  xdata_t       i_src1,
    input  logic         i_use_imm,
    input  logic         i_rd_wen,
    input  preg_idx_t    i_iprd_idx,
    input  rob_idx_t     i_rob_idx,
    input  rob_idx_t     i_irob_idx,
    input  ftq_idx_t     i_ftq_idx,
    input  ftq_off_t     i_ftq_off,
    input  logic         i_wb_stall,
    output logic         o_fu_stall,
    output logic         o_willwrite_vld,
    output preg_idx_t    o_willwrite_rd_idx,
    output xdata_t       o_willwrite_data,
    output logic         o_fu_finished,
    output rob_idx_t     o_wb_rob_idx,
    output rob_idx_t     o_wb_irob_idx,
    output logic         o_wb_use_imm,
    output logic         o_wb_rd_wen,
    output preg_idx_t    o_wb_iprd_idx,
    output xdata_t       o_wb_result,
    output logic         o_branchwb_vld,
    output branch_type_e o_br_type,
    output rob_idx_t     o_br_rob_idx,
    output ftq_idx_t     o_br_ftq_idx,
    output logic         o_br_mispred,
    output logic         o_br_taken,
    output ftq_off_t     o_br_fallthru_off,
    output xdata_t       o_br_target,
    output xdata_t       o_br_npc
);

    logic         stage_en;
    logic         is_branch;
    logic         is_auipc;
    // issue stage fields
    iq_id_t       iss_iq_id;
    micop_e       iss_micop;
    xdata_t       iss_pc;
    xdata_t       iss_pred_npc;
    xdata_t       iss_src0;
    xdata_t       iss_src1;
    logic         iss_use_imm;
    logic         iss_rd_wen;
    preg_idx_t    iss_iprd_idx;
    rob_idx_t     iss_rob_idx;
    rob_idx_t     iss_irob_idx;
    ftq_idx_t     iss_ftq_idx;
    ftq_off_t     iss_ftq_off;
    xdata_t       imm_ext;
    xdata_t       fallthru;
    xdata_t       auipc_val;
    // execute results
    xdata_t       alu_result;
    logic         lt;
    logic         ltu;
    logic         eq;
    logic         br_taken;
    xdata_t       br_target;
    xdata_t       br_npc;
    logic         br_mispred;
    branch_type_e br_type;

    alu_bru_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_vld           (i_vld),
        .i_wb_stall      (i_wb_stall),
        .i_iq_id         (iss_iq_id),
        .i_micop         (iss_micop),
        .i_rd_wen        (iss_rd_wen),
        .o_stage_en      (stage_en),
        .o_fu_stall      (o_fu_stall),
        .o_is_branch     (is_branch),
        .o_is_auipc      (is_auipc),
        .o_willwrite_vld (o_willwrite_vld),
        .o_fu_finished   (o_fu_finished),
        .o_branchwb_vld  (o_branchwb_vld)
    );

    operand_stage u_operand_stage (
        .clk         (clk),
        .i_stage_en  (stage_en),
        .i_iq_id     (i_iq_id),
        .i_micop     (i_micop),
        .i_pc        (i_pc),
        .i_pred_npc  (i_pred_npc),
        .i_imm20     (i_imm20),
        .i_src0      (i_src0),
        .i_src1      (i_src1),
        .i_use_imm   (i_use_imm),
        .i_rd_wen    (i_rd_wen),
        .i_iprd_idx  (i_iprd_idx),
        .i_rob_idx   (i_rob_idx),
        .i_irob_idx  (i_irob_idx),
        .i_ftq_idx   (i_ftq_idx),
        .i_ftq_off   (i_ftq_off),
        .o_iq_id     (iss_iq_id),
        .o_micop     (iss_micop),
        .o_pc        (iss_pc),
        .o_pred_npc  (iss_pred_npc),
        .o_src0      (iss_src0),
        .o_src1      (iss_src1),
        .o_use_imm   (iss_use_imm),
        .o_rd_wen    (iss_rd_wen),
        .o_iprd_idx  (iss_iprd_idx),
        .o_rob_idx   (iss_rob_idx),
        .o_irob_idx  (iss_irob_idx),
        .o_ftq_idx   (iss_ftq_idx),
        .o_ftq_off   (iss_ftq_off),
        .o_imm_ext   (imm_ext),
        .o_fallthru  (fallthru),
        .o_auipc_val (auipc_val)
    );

    alu_calc u_alu_calc (
        .i_micop  (iss_micop),
        .i_src0   (iss_src0),
        .i_src1   (iss_src1),
        .o_result (alu_result),
        .o_lt     (lt),
        .o_ltu    (ltu),
        .o_eq     (eq)
    );

    branch_resolve u_branch_resolve (
        .i_micop     (iss_micop),
        .i_is_branch (is_branch),
        .i_pc        (iss_pc),
        .i_pred_npc  (iss_pred_npc),
        .i_src0      (iss_src0),
        .i_imm_ext   (imm_ext),
        .i_fallthru  (fallthru),
        .i_iprd_idx  (iss_iprd_idx),
        .i_lt        (lt),
        .i_ltu       (ltu),
        .i_eq        (eq),
        .o_taken     (br_taken),
        .o_target    (br_target),
        .o_npc       (br_npc),
        .o_mispred   (br_mispred),
        .o_type      (br_type)
    );

    wb_stage u_wb_stage (
        .clk                (clk),
        .i_stage_en         (stage_en),
        .i_is_branch        (is_branch),
        .i_is_auipc         (is_auipc),
        .i_alu_result       (alu_result),
        .i_fallthru         (fallthru),
        .i_auipc_val        (auipc_val),
        .i_rob_idx          (iss_rob_idx),
        .i_irob_idx         (iss_irob_idx),
        .i_use_imm          (iss_use_imm),
        .i_rd_wen           (iss_rd_wen),
        .i_iprd_idx         (iss_iprd_idx),
        .i_ftq_idx          (iss_ftq_idx),
        .i_ftq_off          (iss_ftq_off),
        .i_taken            (br_taken),
        .i_target           (br_target),
        .i_npc              (br_npc),
        .i_mispred          (br_mispred),
        .i_type             (br_type),
        .o_willwrite_rd_idx (o_willwrite_rd_idx),
        .o_willwrite_data   (o_willwrite_data),
        .o_wb_rob_idx       (o_wb_rob_idx),
        .o_wb_irob_idx      (o_wb_irob_idx),
        .o_wb_use_imm       (o_wb_use_imm),
        .o_wb_rd_wen        (o_wb_rd_wen),
        .o_wb_iprd_idx      (o_wb_iprd_idx),
        .o_wb_result        (o_wb_result),
        .o_br_type          (o_br_type),
        .o_br_rob_idx       (o_br_rob_idx),
        .o_br_ftq_idx       (o_br_ftq_idx),
        .o_br_mispred       (o_br_mispred),
        .o_br_taken         (o_br_taken),
        .o_br_fallthru_off  (o_br_fallthru_off),
        .o_br_target        (o_br_target),
        .o_br_npc           (o_br_npc)
    );

endmodule

// ==== bench/alu_bru_tb.sv ====
`timescale 1ns/100ps

`include "alu_bru_defs.svh"

module alu_bru_tb
    import fu_types_pkg::*;
    import fu_op_pkg::*;
();

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = 4 * N_OPS + 100;
    localparam xdata_t SIGN_BIT   = xdata_t'(1) << (`ALU_BRU_XLEN - 1);

    logic         clk;
    logic         rst;
    logic         i_vld;
    iq_id_t       i_iq_id;
    micop_e       i_micop;
    xdata_t       i_pc;
    xdata_t       i_pred_npc;
    imm20_t       i_imm20;
    xdata_t       i_src0;
    xdata_t       i_src1;
    logic         i_use_imm;
    logic         i_rd_wen;
    preg_idx_t    i_iprd_idx;
    rob_idx_t     i_rob_idx;
    rob_idx_t     i_irob_idx;
    ftq_idx_t     i_ftq_idx;
    ftq_off_t     i_ftq_off;
    logic         i_wb_stall;
    logic         o_fu_stall;
    logic         o_willwrite_vld;
    preg_idx_t    o_willwrite_rd_idx;
    xdata_t       o_willwrite_data;
    logic         o_fu_finished;
    rob_idx_t     o_wb_rob_idx;
    rob_idx_t     o_wb_irob_idx;
    logic         o_wb_use_imm;
    logic         o_wb_rd_wen;
    preg_idx_t    o_wb_iprd_idx;
    xdata_t       o_wb_result;
    logic         o_branchwb_vld;
    branch_type_e o_br_type;
    rob_idx_t     o_br_rob_idx;
    ftq_idx_t     o_br_ftq_idx;
    logic         o_br_mispred;
    logic         o_br_taken;
    ftq_off_t     o_br_fallthru_off;
    xdata_t       o_br_target;
    xdata_t       o_br_npc;

    // expected records, one slot per issued op
    xdata_t       exp_result [0:N_OPS-1];
    logic         exp_is_br [0:N_OPS-1];
    logic         exp_taken [0:N_OPS-1];
    xdata_t       exp_target [0:N_OPS-1];
    xdata_t       exp_npc [0:N_OPS-1];
    logic         exp_mispred [0:N_OPS-1];
    branch_type_e exp_type [0:N_OPS-1];
    rob_idx_t     exp_rob [0:N_OPS-1];
    rob_idx_t     exp_irob [0:N_OPS-1];
    logic         exp_use_imm [0:N_OPS-1];
    logic         exp_rd_wen [0:N_OPS-1];
    preg_idx_t    exp_iprd [0:N_OPS-1];
    ftq_idx_t     exp_ftq [0:N_OPS-1];
    ftq_off_t     exp_off [0:N_OPS-1];
    int           exp_acc [0:N_OPS-1];

    int           pend_q[$];
    integer       seed;
    int           drv_idx = 0;
    int           en_edges = 0;
    int           cycle_cnt = 0;
    int           ops_checked = 0;
    int           mismatch_cnt = 0;
    int           other_cnt = 0;
    logic         held_edge = 1'b0;
    logic         snap_vld = 1'b0;
    logic [307:0] out_now;
    logic [307:0] out_prev;

    assign out_now = {o_willwrite_vld, o_willwrite_rd_idx, o_willwrite_data, o_fu_finished,
                      o_wb_rob_idx, o_wb_irob_idx, o_wb_use_imm, o_wb_rd_wen, o_wb_iprd_idx,
                      o_wb_result, o_branchwb_vld, o_br_type, o_br_rob_idx, o_br_ftq_idx,
                      o_br_mispred, o_br_taken, o_br_fallthru_off, o_br_target, o_br_npc};

    alu_bru u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic xdata_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xdata_t sext20(input imm20_t imm);
        return {{(`ALU_BRU_XLEN-20){imm[19]}}, imm};
    endfunction

    // signed compare by flipping the sign bits
    function automatic logic signed_lt(input xdata_t a, input xdata_t b);
        return (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
    endfunction

    function automatic xdata_t alu_ref(input micop_e op, input xdata_t a, input xdata_t b);
        xdata_t r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a + ~b + xdata_t'(1);
            op_sll:  r = a << b[5:0];
            op_slt:  r = xdata_t'(signed_lt(a, b));
            op_sltu: r = xdata_t'(a < b);
            op_xor:  r = a ^ b;
            op_srl:  r = a >> b[5:0];
            op_sra: begin
                r = a >> b[5:0];
                if (a & SIGN_BIT)
                    r = r | ~({`ALU_BRU_XLEN{1'b1}} >> b[5:0]);
            end
            op_or:   r = a | b;
            op_and:  r = a & b;
            op_lui:  r = b;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic branch_type_e br_type_ref(input micop_e op, input preg_idx_t rd);
        if (op == op_jalr)
            return (rd == 1) ? br_call : (rd == 0) ? br_ret : br_indirect;
        if (op == op_jal)
            return br_direct;
        if (op >= op_beq && op <= op_bgeu)
            return br_cond;
        return br_none;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_payload;
        i_iq_id    = iq_id_t'(urand(4));
        i_micop    = micop_e'(urand(20));
        i_pc       = rand64() & ~xdata_t'(3);
        i_pred_npc = rand64();
        i_imm20    = imm20_t'($random(seed));
        i_src0     = rand64();
        i_src1     = rand64();
        i_use_imm  = (urand(2) == 1);
        i_rd_wen   = (urand(4) != 0);
        i_iprd_idx = preg_idx_t'($random(seed));
        i_rob_idx  = rob_idx_t'($random(seed));
        i_irob_idx = rob_idx_t'($random(seed));
        i_ftq_idx  = ftq_idx_t'($random(seed));
        i_ftq_off  = ftq_off_t'($random(seed));
    endtask

    // random op on the inputs plus its expected records
    task automatic make_op(input int idx);
        int     kind;
        micop_e op;
        xdata_t imm_ext;
        xdata_t link;
        xdata_t target;
        xdata_t npc;
        logic   taken;
        logic   is_br;
        drive_payload();
        kind = urand(10);
        if (kind < 5) begin
            i_iq_id = iq_id_t'(`ALU_BRU_ALUIQ_ID);
            op = micop_e'(urand(11));
        end else begin
            i_iq_id = iq_id_t'(`ALU_BRU_BRUIQ_ID);
            case (kind)
                5: op = op_auipc;
                6: op = op_jal;
                7: op = op_jalr;
                default: op = micop_e'(int'(op_beq) + urand(6));
            endcase
        end
        i_micop = op;
        // equal operands so beq and bge get taken now and then
        if (urand(4) == 0)
            i_src1 = i_src0;
        if (op == op_jalr && urand(3) != 2)
            i_iprd_idx = preg_idx_t'(urand(2));
        imm_ext = sext20(i_imm20);
        link = i_pc + 64'd4;
        is_br = (op >= op_jal);
        case (op)
            op_jal, op_jalr: taken = 1'b1;
            op_beq:  taken = (i_src0 == i_src1);
            op_bne:  taken = (i_src0 != i_src1);
            op_blt:  taken = signed_lt(i_src0, i_src1);
            op_bge:  taken = !signed_lt(i_src0, i_src1);
            op_bltu: taken = (i_src0 < i_src1);
            op_bgeu: taken = (i_src0 >= i_src1);
            default: taken = 1'b0;
        endcase
        target = (op == op_jalr) ? i_src0 + imm_ext : i_pc + imm_ext;
        npc = taken ? target : link;
        if (urand(2) == 1)
            i_pred_npc = npc;
        if (is_br)
            exp_result[idx] = link;
        else if (op == op_auipc)
            exp_result[idx] = i_pc + (imm_ext << 12);
        else
            exp_result[idx] = alu_ref(op, i_src0, i_src1);
        exp_is_br[idx]   = is_br;
        exp_taken[idx]   = taken;
        exp_target[idx]  = target;
        exp_npc[idx]     = npc;
        exp_mispred[idx] = is_br && (npc != i_pred_npc);
        exp_type[idx]    = br_type_ref(op, i_iprd_idx);
        exp_rob[idx]     = i_rob_idx;
        exp_irob[idx]    = i_irob_idx;
        exp_use_imm[idx] = i_use_imm;
        exp_rd_wen[idx]  = i_rd_wen;
        exp_iprd[idx]    = i_iprd_idx;
        exp_ftq[idx]     = i_ftq_idx;
        exp_off[idx]     = i_ftq_off + ftq_off_t'(4);
    endtask

    // counts enabled edges and records when each op was accepted
    always @(posedge clk) begin : track_issue
        if (!rst && !i_wb_stall) begin
            en_edges = en_edges + 1;
            if (i_vld) begin
                exp_acc[drv_idx] = en_edges;
                pend_q.push_back(drv_idx);
            end
        end
        held_edge = !rst && i_wb_stall;
    end

    always @(negedge clk) begin : check_outputs
        int   h;
        int   t;
        logic due;
        logic in_iss;
        if (!rst) begin
            h = 0;
            t = 0;
            due = 1'b0;
            in_iss = 1'b0;
            if (pend_q.size() > 0) begin
                h = pend_q[0];
                t = pend_q[pend_q.size()-1];
                due = (exp_acc[h] + 1 == en_edges);
                in_iss = (exp_acc[t] == en_edges);
            end
            check_value("o_fu_stall", o_fu_stall, i_wb_stall);
            check_value("o_willwrite_vld", o_willwrite_vld, in_iss && exp_rd_wen[t]);
            if (in_iss) begin
                check_value("o_willwrite_rd_idx", o_willwrite_rd_idx, exp_iprd[t]);
                check_value("o_willwrite_data", o_willwrite_data, exp_result[t]);
            end
            check_value("o_fu_finished", o_fu_finished, due);
            check_value("o_branchwb_vld", o_branchwb_vld, due && exp_is_br[h]);
            if (due) begin
                check_value("o_wb_rob_idx", o_wb_rob_idx, exp_rob[h]);
                check_value("o_wb_irob_idx", o_wb_irob_idx, exp_irob[h]);
                check_value("o_wb_use_imm", o_wb_use_imm, exp_use_imm[h]);
                check_value("o_wb_rd_wen", o_wb_rd_wen, exp_rd_wen[h]);
                check_value("o_wb_iprd_idx", o_wb_iprd_idx, exp_iprd[h]);
                check_value("o_wb_result", o_wb_result, exp_result[h]);
                if (exp_is_br[h]) begin
                    check_value("o_br_type", o_br_type, exp_type[h]);
                    check_value("o_br_rob_idx", o_br_rob_idx, exp_rob[h]);
                    check_value("o_br_ftq_idx", o_br_ftq_idx, exp_ftq[h]);
                    check_value("o_br_mispred", o_br_mispred, exp_mispred[h]);
                    check_value("o_br_taken", o_br_taken, exp_taken[h]);
                    check_value("o_br_fallthru_off", o_br_fallthru_off, exp_off[h]);
                    check_value("o_br_target", o_br_target, exp_target[h]);
                    check_value("o_br_npc", o_br_npc, exp_npc[h]);
                end
            end
            // nothing may move across a stalled edge
            if (held_edge && snap_vld) begin
                assert (out_now === out_prev) else begin
                    mismatch_cnt++;
                    $display("mismatch at %0t: outputs across stall got %h expected %h",
                             $time, out_now, out_prev);
                end
            end
            out_prev = out_now;
            snap_vld = 1'b1;
            // record leaves the wb stage at the next edge
            if (due && !i_wb_stall) begin
                h = pend_q.pop_front();
            end
            // dut writeback counted as it leaves
            if (o_fu_finished && !i_wb_stall) begin
                ops_checked++;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d ops pending, %0d mismatches, %0d other",
                     TIMEOUT_CYCLES, pend_q.size(), mismatch_cnt, other_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        int   ops_sent;
        int   stall_left;
        logic stalled;
        seed = 32'he7e9f805;
        ops_sent = 0;
        stall_left = 0;
        rst = 1'b1;
        // valid held high during reset, the flops must still clear
        i_vld = 1'b1;
        i_wb_stall = 1'b0;
        drive_payload();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        i_vld = 1'b0;
        // idle cycles check the reset state
        repeat (3) @(posedge clk);
        while (ops_sent < N_OPS) begin
            @(posedge clk);
            #2;
            if (stall_left > 0) begin
                stall_left--;
                stalled = 1'b1;
            end else if (urand(8) == 0) begin
                stall_left = urand(4);
                stalled = 1'b1;
            end else begin
                stalled = 1'b0;
            end
            i_wb_stall = stalled;
            if (stalled) begin
                // offered during a stall, must be dropped
                drive_payload();
                i_vld = (urand(2) == 1);
            end else if (urand(8) != 0) begin
                make_op(ops_sent);
                drv_idx = ops_sent;
                i_vld = 1'b1;
                ops_sent++;
            end else begin
                i_vld = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        i_vld = 1'b0;
        i_wb_stall = 1'b0;
        // wait for the dut to write back every op
        while (ops_checked < N_OPS || pend_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        if (ops_checked != N_OPS) begin
            other_cnt++;
            $display("%0d ops were written back but %0d were issued", ops_checked, N_OPS);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d ops written back",
                 mismatch_cnt, other_cnt, ops_checked);
        if (mismatch_cnt + other_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== alu_bru.f ====
+incdir+include
rtl/fu_types_pkg.sv
rtl/fu_op_pkg.sv
rtl/alu_bru_ctrl.sv
rtl/operand_stage.sv
rtl/alu_calc.sv
rtl/branch_resolve.sv
rtl/wb_stage.sv
rtl/alu_bru.sv
bench/alu_bru_tb.sv
